// ==== all.f ====
common/lsu_pkg.sv
rtl/lsu_addr_gen.sv
mem_access/data_ram.sv
mem_access/mem_access.sv
rtl/lsu_top.sv
tests/tb_clock.sv
tests/lsu_assert.sv
tests/lsu_tb.sv

// ==== common/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Datapath widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam int xlen        = 32;           // RV32 data word.
   localparam int lane_w      = xlen / 8;     // Byte lanes per word.
   localparam int imm_w       = 12;           // I/S-type immediate.
   localparam int addr_w      = 12;           // Byte address, 4 KiB.
   localparam int word_addr_w = addr_w - 2;   // Drops the byte offset.
   localparam int ram_words   = 1024;         // Data RAM depth.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Memory opcodes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Loads first, then stores; op_none passes the ALU result through.
   typedef enum logic [3:0] {
      op_none = 4'd0,   // Not a memory instruction.
      op_lb   = 4'd1,   // Byte, sign-extended.
      op_lh   = 4'd2,   // Halfword, sign-extended.
      op_lw   = 4'd3,   // Full word.
      op_lbu  = 4'd4,   // Byte, zero-extended.
      op_lhu  = 4'd5,   // Halfword, zero-extended.
      op_sb   = 4'd6,   // Store byte.
      op_sh   = 4'd7,   // Store halfword.
      op_sw   = 4'd8    // Store word.
   } mem_op_t;

endpackage

`default_nettype wire

// ==== mem_access/data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_ram (
   input  logic                            clk,
   input  logic [lsu_pkg::lane_w-1:0]      rden,
   input  logic [lsu_pkg::lane_w-1:0]      wren,
   input  logic [lsu_pkg::xlen-1:0]        wrdata,
   input  logic [lsu_pkg::word_addr_w-1:0] word_addr,
   output logic [lsu_pkg::xlen-1:0]        rddata
);
   import lsu_pkg::*;

   logic [xlen-1:0] mem [ram_words];   // Word-organized storage.

   // Per-lane write, one byte enable per lane.
   always_ff @(posedge clk) begin
      for (int i = 0; i < lane_w; i++) begin
         if (wren[i]) begin
            mem[word_addr][i*8 +: 8] <= wrdata[i*8 +: 8];
         end
      end
   end

   // Whole word is read; the lane pick happens downstream.
   always_ff @(posedge clk) begin
      if (|rden) begin
         rddata <= mem[word_addr];       // Holds when no lane is read.
      end
   end

endmodule

`default_nettype wire

// ==== mem_access/mem_access.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_access (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        ex_vld,
   input  logic [lsu_pkg::xlen-1:0]    ex_result,
   input  logic [lsu_pkg::lane_w-1:0]  rden,
   input  logic [lsu_pkg::lane_w-1:0]  wren,
   input  logic [lsu_pkg::xlen-1:0]    wrdata,
   input  logic [lsu_pkg::addr_w-1:0]  addr,
   input  logic                        load_signed,
   input  logic                        ex_misaligned,
   output logic                        result_vld,
   output logic [lsu_pkg::xlen-1:0]    result,
   output logic                        misaligned
);
   import lsu_pkg::*;

   logic [xlen-1:0]   rddata;          // RAM word, valid one cycle after rden.
   logic [xlen-1:0]   ex_result_d;     // Pass-through value, delayed.
   logic [lane_w-1:0] rden_d;          // Lanes that were read.
   logic              load_signed_d;

   data_ram u_data_ram (
      .clk       (clk),
      .rden      (rden),
      .wren      (wren),
      .wrdata    (wrdata),
      .word_addr (addr[addr_w-1:2]),   // Byte offset dropped.
      .rddata    (rddata)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Align with the RAM read latency
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (rst) begin
         result_vld <= 1'b0;
         rden_d     <= '0;
         misaligned <= 1'b0;
      end else begin
         result_vld <= ex_vld;
         rden_d     <= rden;
         misaligned <= ex_misaligned;
      end
   end

   always_ff @(posedge clk) begin
      ex_result_d   <= ex_result;
      load_signed_d <= load_signed;
   end

   // Lane select and extension; the sign bit only fills when lb/lh.
   always_comb begin
      case (rden_d)
         4'b0001: result = {{24{load_signed_d & rddata[7]}},  rddata[7:0]};
         4'b0010: result = {{24{load_signed_d & rddata[15]}}, rddata[15:8]};
         4'b0100: result = {{24{load_signed_d & rddata[23]}}, rddata[23:16]};
         4'b1000: result = {{24{load_signed_d & rddata[31]}}, rddata[31:24]};
         4'b0011: result = {{16{load_signed_d & rddata[15]}}, rddata[15:0]};
         4'b1100: result = {{16{load_signed_d & rddata[31]}}, rddata[31:16]};
         4'b1111: result = rddata;                    // Word, no extension.
         default: result = ex_result_d;               // Non-load or misaligned.
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/lsu_addr_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_addr_gen (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        op_vld,
   input  lsu_pkg::mem_op_t            op,
   input  logic [lsu_pkg::xlen-1:0]    base,
   input  logic [lsu_pkg::imm_w-1:0]   offset,
   input  logic [lsu_pkg::xlen-1:0]    store_data,
   input  logic [lsu_pkg::xlen-1:0]    alu_result,
   output logic                        ex_vld,
   output logic [lsu_pkg::xlen-1:0]    ex_result,
   output logic [lsu_pkg::lane_w-1:0]  rden,
   output logic [lsu_pkg::lane_w-1:0]  wren,
   output logic [lsu_pkg::xlen-1:0]    wrdata,
   output logic [lsu_pkg::addr_w-1:0]  addr,
   output logic                        load_signed,
   output logic                        ex_misaligned
);
   import lsu_pkg::*;

   logic [xlen-1:0]   ea;          // Effective address, full width.
   logic [lane_w-1:0] byte_lane;   // One-hot lane for byte access.
   logic [lane_w-1:0] half_lane;   // Lane pair for halfword access.
   logic [lane_w-1:0] rd_mask;
   logic [lane_w-1:0] wr_mask;
   logic [xlen-1:0]   lane_data;   // Store data moved into its lanes.
   logic              mis;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Address and lane decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign ea        = base + {{(xlen-imm_w){offset[imm_w-1]}}, offset};   // rs1 + sext(imm).
   assign byte_lane = lane_w'(1) << ea[1:0];
   assign half_lane = ea[1] ? 4'b1100 : 4'b0011;                         // Upper or lower half.

   always_comb begin
      rd_mask   = '0;
      wr_mask   = '0;
      mis       = 1'b0;
      lane_data = store_data;                       // Word store default.
      case (op)
         op_lb, op_lbu: rd_mask = byte_lane;          // Any byte address is fine.
         op_lh, op_lhu: begin
            mis     = ea[0];                        // Needs even address.
            rd_mask = ea[0] ? '0 : half_lane;
         end
         op_lw: begin
            mis     = |ea[1:0];                     // Needs word address.
            rd_mask = mis ? '0 : '1;
         end
         op_sb: begin
            wr_mask   = byte_lane;
            lane_data = {lane_w{store_data[7:0]}};  // Byte in every lane.
         end
         op_sh: begin
            mis       = ea[0];
            wr_mask   = ea[0] ? '0 : half_lane;
            lane_data = {2{store_data[15:0]}};      // Half in both halves.
         end
         op_sw: begin
            mis     = |ea[1:0];
            wr_mask = mis ? '0 : '1;
         end
         default: ;                                 // op_none, no access.
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Execute-to-memory register
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_vld        <= 1'b0;
         rden          <= '0;
         wren          <= '0;
         ex_misaligned <= 1'b0;
      end else begin
         ex_vld        <= op_vld;
         rden          <= op_vld ? rd_mask : '0;    // Idle slot, no access.
         wren          <= op_vld ? wr_mask : '0;
         ex_misaligned <= op_vld & mis;
      end
   end

   // Payload, meaningful only alongside ex_vld.
   always_ff @(posedge clk) begin
      ex_result   <= alu_result;
      wrdata      <= lane_data;
      addr        <= ea[addr_w-1:0];                // Wraps within 4 KiB.
      load_signed <= (op == op_lb) || (op == op_lh);
   end

endmodule

`default_nettype wire

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_top (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        op_vld,
   input  lsu_pkg::mem_op_t            op,
   input  logic [lsu_pkg::xlen-1:0]    base,
   input  logic [lsu_pkg::imm_w-1:0]   offset,
   input  logic [lsu_pkg::xlen-1:0]    store_data,
   input  logic [lsu_pkg::xlen-1:0]    alu_result,
   output logic                        result_vld,
   output logic [lsu_pkg::xlen-1:0]    result,
   output logic                        misaligned
);
   import lsu_pkg::*;

   // Execute-to-memory boundary.
   logic              ex_vld;
   logic [xlen-1:0]   ex_result;
   logic [lane_w-1:0] rden;
   logic [lane_w-1:0] wren;
   logic [xlen-1:0]   wrdata;
   logic [addr_w-1:0] addr;
   logic              load_signed;
   logic              ex_misaligned;

   lsu_addr_gen u_lsu_addr_gen (
      .clk           (clk),
      .rst           (rst),
      .op_vld        (op_vld),
      .op            (op),
      .base          (base),
      .offset        (offset),
      .store_data    (store_data),
      .alu_result    (alu_result),
      .ex_vld        (ex_vld),
      .ex_result     (ex_result),
      .rden          (rden),
      .wren          (wren),
      .wrdata        (wrdata),
      .addr          (addr),
      .load_signed   (load_signed),
      .ex_misaligned (ex_misaligned)
   );

   mem_access u_mem_access (
      .clk           (clk),
      .rst           (rst),
      .ex_vld        (ex_vld),
      .ex_result     (ex_result),
      .rden          (rden),
      .wren          (wren),
      .wrdata        (wrdata),
      .addr          (addr),
      .load_signed   (load_signed),
      .ex_misaligned (ex_misaligned),
      .result_vld    (result_vld),
      .result        (result),
      .misaligned    (misaligned)
   );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Compile the LSU testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns \
   -f all.f --top-module lsu_tb -o lsu_sim || exit 1
out="$(./obj_dir/lsu_sim)"
echo "$out"
echo "$out" | grep -q "^TEST PASSED$" && exit 0 || exit 1

// ==== tests/lsu_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_assert (
   input logic                        clk,
   input logic                        rst,
   input logic                        ex_vld,
   input logic [lsu_pkg::lane_w-1:0]  rden,
   input logic [lsu_pkg::lane_w-1:0]  wren,
   input logic                        result_vld
);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Lane masks and valid timing
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   legal_rden_a: assert property (@(posedge clk) disable iff (rst)
      (rden != '0) |-> (rden inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                     4'b0011, 4'b1100, 4'b1111}))
      else $error("Read lane mask %b is not a byte, halfword or word mask", rden);

   // A slot either loads or stores, never both.
   rd_wr_excl_a: assert property (@(posedge clk) disable iff (rst)
      !((rden != '0) && (wren != '0)))
      else $error("Read mask %b and write mask %b active together", rden, wren);

   vld_delay_a: assert property (@(posedge clk) disable iff (rst)
      result_vld == $past(ex_vld))
      else $error("result_vld does not follow ex_vld by one cycle");

endmodule

bind mem_access lsu_assert lsu_assert_i (
   .clk        (clk),
   .rst        (rst),
   .ex_vld     (ex_vld),
   .rden       (rden),
   .wren       (wren),
   .result_vld (result_vld)
);

`default_nettype wire

// ==== tests/lsu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module lsu_tb;
   import lsu_pkg::*;

   typedef struct packed {
      logic [95:0]      name;         // Up to 12 characters.
      mem_op_t          op;
      logic [xlen-1:0]  base;
      logic [imm_w-1:0] offset;
      logic [xlen-1:0]  store_data;
      logic [xlen-1:0]  alu_result;
      logic             has_result;   // Low for an idle slot.
   } row_t;

   localparam int n_rows   = 30;
   localparam int n_random = 40;
   localparam int wait_max = 20;      // Cycles before a wait gives up.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Directed stimulus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   localparam row_t rows [n_rows] = '{
      '{"sw_word",      op_sw,   32'h100, 12'h010, 32'hdead_beef, 32'h0000_0011, 1'b1},
      '{"lw_word",      op_lw,   32'h100, 12'h010, 32'h0000_0000, 32'h0000_0022, 1'b1},
      '{"lw_untouched", op_lw,   32'h200, 12'h000, 32'h0000_0000, 32'h0000_0033, 1'b1},
      '{"sb_lane0",     op_sb,   32'h120, 12'h000, 32'haaaa_aa11, 32'h0000_0001, 1'b1},
      '{"sb_lane1",     op_sb,   32'h120, 12'h001, 32'h0000_0082, 32'h0000_0002, 1'b1},
      '{"sb_lane2",     op_sb,   32'h120, 12'h002, 32'h5555_557f, 32'h0000_0003, 1'b1},
      '{"sb_lane3",     op_sb,   32'h120, 12'h003, 32'h0000_00f4, 32'h0000_0004, 1'b1},
      '{"lw_bytes",     op_lw,   32'h120, 12'h000, 32'h0000_0000, 32'h0000_0005, 1'b1},
      '{"lbu_lane0",    op_lbu,  32'h120, 12'h000, 32'h0000_0000, 32'h0000_0006, 1'b1},
      '{"lbu_lane1",    op_lbu,  32'h120, 12'h001, 32'h0000_0000, 32'h0000_0007, 1'b1},
      '{"lbu_lane2",    op_lbu,  32'h120, 12'h002, 32'h0000_0000, 32'h0000_0017, 1'b1},
      '{"lbu_lane3",    op_lbu,  32'h124, 12'hfff, 32'h0000_0000, 32'h0000_0008, 1'b1},
      '{"lb_lane1",     op_lb,   32'h120, 12'h001, 32'h0000_0000, 32'h0000_0009, 1'b1},
      '{"lb_lane2",     op_lb,   32'h120, 12'h002, 32'h0000_0000, 32'h0000_000a, 1'b1},
      '{"lb_lane3",     op_lb,   32'h124, 12'hfff, 32'h0000_0000, 32'h0000_000b, 1'b1},
      '{"sh_lower",     op_sh,   32'h140, 12'h000, 32'h1234_8001, 32'h0000_000c, 1'b1},
      '{"sh_upper",     op_sh,   32'h140, 12'h002, 32'h0000_7ffe, 32'h0000_000d, 1'b1},
      '{"lh_lower",     op_lh,   32'h140, 12'h000, 32'h0000_0000, 32'h0000_000e, 1'b1},
      '{"lhu_lower",    op_lhu,  32'h140, 12'h000, 32'h0000_0000, 32'h0000_000f, 1'b1},
      '{"lh_upper",     op_lh,   32'h140, 12'h002, 32'h0000_0000, 32'h0000_0010, 1'b1},
      '{"lhu_upper",    op_lhu,  32'h144, 12'hffe, 32'h0000_0000, 32'h0000_0011, 1'b1},
      '{"none_pass",    op_none, 32'h110, 12'h000, 32'h0bad_f00d, 32'hcafe_f00d, 1'b1},
      '{"lw_post_none", op_lw,   32'h110, 12'h000, 32'h0000_0000, 32'h0000_0012, 1'b1},
      '{"lw_misalign",  op_lw,   32'h000, 12'h002, 32'h0000_0000, 32'h0000_beef, 1'b1},
      '{"sh_misalign",  op_sh,   32'h141, 12'h000, 32'h0000_ffff, 32'h0000_0777, 1'b1},
      '{"lw_post_mis",  op_lw,   32'h140, 12'h000, 32'h0000_0000, 32'h0000_0013, 1'b1},
      '{"idle",         op_none, 32'h000, 12'h000, 32'h0000_0000, 32'h0000_0000, 1'b0},
      '{"sw_b2b",       op_sw,   32'h180, 12'h000, 32'h0102_0304, 32'h0000_0014, 1'b1},
      '{"lw_b2b",       op_lw,   32'h180, 12'h000, 32'h0000_0000, 32'h0000_0015, 1'b1},
      '{"lb_b2b",       op_lb,   32'h17f, 12'h002, 32'h0000_0000, 32'h0000_0016, 1'b1}
   };

   logic              clk;
   logic              rst;
   logic              op_vld;
   mem_op_t           op;
   logic [xlen-1:0]   base;
   logic [imm_w-1:0]  offset;
   logic [xlen-1:0]   store_data;
   logic [xlen-1:0]   alu_result;
   logic              result_vld;
   logic [xlen-1:0]   result;
   logic              misaligned;

   logic [7:0]        model_mem [1 << addr_w];   // Byte-wide reference memory.
   string             exp_name [$];
   logic [xlen-1:0]   exp_value [$];
   logic              exp_mis [$];
   int                exp_cycle [$];             // Cycle in which result_vld is due.
   int                cyc = 0;
   int                pass_cnt = 0;
   int                fail_cnt = 0;
   int                seed = 32'h9b23529a;
   bit                timed_out = 1'b0;

   tb_clock clock_i (.clk(clk), .rst(rst));

   lsu_top dut_i (.*);

   always @(posedge clk) cyc <= cyc + 1;

   // Applies one access to the byte model, in program order.
   function automatic void model_access(input mem_op_t o, input logic [xlen-1:0] b,
                                        input logic [imm_w-1:0] off, input logic [xlen-1:0] sd,
                                        input logic [xlen-1:0] alu,
                                        output logic [xlen-1:0] val, output logic mis);
      logic [xlen-1:0]   ea;
      logic [addr_w-1:0] a;
      ea  = b + {{20{off[11]}}, off};
      a   = ea[addr_w-1:0];
      val = alu;                                       // Non-loads pass through.
      mis = 1'b0;
      case (o)
         op_lb:  val = {{24{model_mem[a][7]}}, model_mem[a]};
         op_lbu: val = {24'h0, model_mem[a]};
         op_lh, op_lhu: begin
            mis = a[0];
            if (!mis)
               val = {(o == op_lh) ? {16{model_mem[a + 12'd1][7]}} : 16'h0,
                      model_mem[a + 12'd1], model_mem[a]};
         end
         op_lw: begin
            mis = |a[1:0];
            if (!mis)
               val = {model_mem[a + 12'd3], model_mem[a + 12'd2],
                      model_mem[a + 12'd1], model_mem[a]};
         end
         op_sb: model_mem[a] = sd[7:0];
         op_sh: begin
            mis = a[0];
            if (!mis) begin
               model_mem[a]         = sd[7:0];
               model_mem[a + 12'd1] = sd[15:8];
            end
         end
         op_sw: begin
            mis = |a[1:0];
            if (!mis) begin
               for (int i = 0; i < lane_w; i++) model_mem[a + 12'(i)] = sd[i*8 +: 8];
            end
         end
         default: ;                                    // op_none.
      endcase
   endfunction

   task automatic issue_op(input string name, input logic vld, input mem_op_t o,
                           input logic [xlen-1:0] b, input logic [imm_w-1:0] off,
                           input logic [xlen-1:0] sd, input logic [xlen-1:0] alu);
      logic [xlen-1:0] val;
      logic            mis;
      @(posedge clk);
      op_vld     <= vld;
      op         <= o;
      base       <= b;
      offset     <= off;
      store_data <= sd;
      alu_result <= alu;
      if (vld) begin
         model_access(o, b, off, sd, alu, val, mis);
         exp_name.push_back(name);
         exp_value.push_back(val);
         exp_mis.push_back(mis);
         exp_cycle.push_back(cyc + 3);                 // Two cycles after the op is presented.
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Result checker, sampled mid-cycle
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic check_result();
      string           name;
      logic [xlen-1:0] e_val;
      logic            e_mis;
      int              e_cyc;
      bit              ok;
      if (exp_name.size() == 0) begin
         $display("result_vld was high with no operation outstanding");
         fail_cnt++;
      end else begin
         name  = exp_name.pop_front();
         e_val = exp_value.pop_front();
         e_mis = exp_mis.pop_front();
         e_cyc = exp_cycle.pop_front();
         ok    = 1'b1;
         assert (result === e_val) else begin
            $display("FAIL %s: result expected %h, actual %h", name, e_val, result);
            ok = 1'b0;
         end
         assert (misaligned === e_mis) else begin
            $display("FAIL %s: misaligned expected %b, actual %b", name, e_mis, misaligned);
            ok = 1'b0;
         end
         assert (cyc == e_cyc) else begin
            $display("FAIL %s: result_vld cycle expected %0d, actual %0d", name, e_cyc, cyc);
            ok = 1'b0;
         end
         if (ok) begin
            pass_cnt++;
            $display("ok   %s result %h misaligned %b", name, result, misaligned);
         end else begin
            fail_cnt++;
         end
      end
   endtask

   always @(negedge clk) begin
      if (!rst && !result_vld && exp_name.size() > 0 && cyc >= exp_cycle[0]) begin
         $display("Result for %s did not arrive in cycle %0d", exp_name[0], exp_cycle[0]);
         fail_cnt++;
         void'(exp_name.pop_front());
         void'(exp_value.pop_front());
         void'(exp_mis.pop_front());
         void'(exp_cycle.pop_front());
      end
      if (!rst && result_vld) check_result();
   end

   initial begin
      int               waited;
      int               k;
      mem_op_t          o;
      logic [5:0]       mask;
      logic [imm_w-1:0] off;
      op_vld     = 1'b0;
      op         = op_none;
      base       = '0;
      offset     = '0;
      store_data = '0;
      alu_result = '0;
      for (int i = 0; i < (1 << addr_w); i++) model_mem[i] = 8'h00;

      waited = 0;
      @(posedge clk);                                  // Reset is high at the first edge.
      while (rst && waited < wait_max) begin
         @(posedge clk);
         waited++;
      end
      if (rst) begin
         $display("Reset was not released within %0d cycles", wait_max);
         timed_out = 1'b1;
      end else begin
         for (int i = 0; i < n_rows; i++) begin
            issue_op($sformatf("%s", rows[i].name), rows[i].has_result, rows[i].op,
                     rows[i].base, rows[i].offset, rows[i].store_data, rows[i].alu_result);
         end
         // Aligned random traffic in 0x300..0x33f, negative offsets from 0x340.
         for (int i = 0; i < n_random; i++) begin
            k = $unsigned($random(seed)) % 8;
            o = mem_op_t'(k + 1);                      // Any load or store.
            case (o)
               op_lh, op_lhu, op_sh: mask = 6'h3e;
               op_lw, op_sw:         mask = 6'h3c;
               default:              mask = 6'h3f;
            endcase
            off = 12'hfc0 | {6'h00, 6'($random(seed)) & mask};
            issue_op($sformatf("rand_%0d", i), 1'b1, o, 32'h340, off,
                     $random(seed), $random(seed));
         end
         issue_op("drain", 1'b0, op_none, '0, '0, '0, '0);
         waited = 0;
         while (exp_name.size() > 0 && waited < wait_max) begin
            @(posedge clk);
            waited++;
         end
         if (exp_name.size() > 0) begin
            $display("Timed out with %0d results outstanding", exp_name.size());
            timed_out = 1'b1;
         end
      end

      $display("Counts: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && !timed_out) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
   output logic clk,
   output logic rst
);
   localparam int half_period = 20;   // 40 ns clock.

   initial begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   // Reset covers the first two rising edges.
   initial begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire
